/* files.f */
common/rv32_isa_pkg.sv
common/decode_pkg.sv
decode/imm_gen.sv
decode/op_decode.sv
source/decode_stage.sv
bench/decode_chk.sv
bench/decode_tb.sv

/* run.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module decode_tb -f files.f -o decode_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/decode_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
    exit 0
fi

echo "pass message not found in $LOG"
exit 1

/* bench/decode_tb.sv */
`timescale 1ns/1ps

module decode_tb
    import rv32_isa_pkg::*;
    import decode_pkg::*;
();

    localparam int WAIT_LIMIT = 8;

    logic        clk;
    logic        rst_n;
    fetch_pkt_t  fetch_pkt;
    logic        queue_empty;
    decode_pkt_t out_pkt;

    integer          seed = 13517;
    int              n_tests, n_checks, n_errors;
    logic [XLEN-1:0] pc_cur;

    string      reg_names [10] = '{"add", "sll", "slt", "sltu", "xor", "srl", "or", "and",
                                   "sub", "sra"};
    string      md_names [8]   = '{"mul", "mulh", "mulhsu", "mulhu", "div", "divu", "rem",
                                   "remu"};
    logic [2:0] br_codes [6]   = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    decode_stage dut0 (
        .clk           (clk),
        .i_rst_n       (rst_n),
        .i_fetch_pkt   (fetch_pkt),
        .i_queue_empty (queue_empty),
        .o_decode_pkt  (out_pkt)
    );

    always #10 clk = ~clk;

    // instruction encoders from the ISA formats
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_br};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    function automatic uop_ctrl_t make_uop(input op_class_t cls, input alu_op_t alu,
            input branch_f3_t cmp, input m1_sel_t m1, input m2_sel_t m2, input logic [4:0] rs1,
            input logic [4:0] rs2, input logic [4:0] rd, input logic use1, input logic use2);
        uop_ctrl_t u;
        u          = '0;
        u.op_class = cls;
        u.alu_op   = alu;
        u.cmp_op   = cmp;
        u.m1_sel   = m1;
        u.m2_sel   = m2;
        u.rs1_addr = rs1;
        u.rs2_addr = rs2;
        u.rd_addr  = rd;
        u.use_rs1  = use1;
        u.use_rs2  = use2;
        return u;
    endfunction

    task automatic compare_pkt(input string name, input decode_pkt_t exp, input decode_pkt_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_class(input string name, input op_class_t exp, input op_class_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("mismatch %s expected %s actual %s", name, exp.name(), act.name());
        end
    endtask

    // drive one instruction and check the packet a cycle later
    task automatic run_inst(input string name, input logic [31:0] inst, input logic vld,
            input logic empty, input logic exp_valid, input uop_ctrl_t uop,
            input logic [XLEN-1:0] imm);
        decode_pkt_t exp;
        int          cyc;
        exp = '0;
        if (exp_valid) begin
            exp.valid = 1'b1;
            exp.pc    = pc_cur;
            exp.uop   = uop;
            exp.imm   = imm;
        end
        @(posedge clk);
        fetch_pkt   <= '{inst: inst, pc: pc_cur, valid: vld};
        queue_empty <= empty;
        cyc = 0;
        do begin
            @(posedge clk);
            @(negedge clk);
            cyc++;
        end while (exp_valid && !out_pkt.valid && cyc < WAIT_LIMIT);
        if (exp_valid && !out_pkt.valid) begin
            $display("%s: output valid did not rise within %0d cycles", name, WAIT_LIMIT);
            $display("TB FAILED");
            $finish;
        end else begin
            if (cyc != 1) begin
                n_errors++;
                $display("%s: output came after %0d cycles instead of one", name, cyc);
            end
            compare_pkt(name, exp, out_pkt);
            pc_cur = pc_cur + 4;
        end
    endtask

    task automatic report_test(input string name, input int err0);
        n_tests++;
        $display("test %-12s done, %0d errors", name, n_errors - err0);
    endtask

    task automatic reset_and_gating();
        int err0;
        err0 = n_errors;
        compare_pkt("after_reset", '0, out_pkt);
        run_inst("queue_empty", i_type(12'h123, 5'd1, 3'd0, 5'd2, op_imm), 1'b1, 1'b1, 1'b0,
                 '0, '0);
        run_inst("input_invalid", i_type(12'h123, 5'd1, 3'd0, 5'd2, op_imm), 1'b0, 1'b0, 1'b0,
                 '0, '0);
        run_inst("unknown_opcode", 32'h0000_0073, 1'b1, 1'b0, 1'b0, '0, '0);  // ecall
        report_test("reset_gating", err0);
    endtask

    task automatic reg_ops();
        int          err0;
        logic [31:0] rnd;
        logic [2:0]  f3;
        logic        alt;
        op_class_t   cls;
        alu_op_t     alu;
        branch_f3_t  cmp;
        err0 = n_errors;
        for (int k = 0; k < 10; k++) begin
            rnd = $random(seed);
            f3  = (k == 8) ? 3'd0 : (k == 9) ? 3'd5 : k[2:0];
            alt = (k >= 8);     // sub and sra
            cls = cls_alu;
            alu = alu_op_t'(f3);
            cmp = branch_f3_beq;
            if (f3 == 3'd2 || f3 == 3'd3) begin
                cls = cls_cmp;
                alu = alu_op_add;
                cmp = (f3 == 3'd2) ? branch_f3_blt : branch_f3_bltu;
            end
            if (k == 8)
                alu = alu_op_sub;
            if (k == 9)
                alu = alu_op_sra;
            run_inst(reg_names[k], r_type({1'b0, alt, 5'b0}, rnd[9:5], rnd[4:0], f3, rnd[14:10]),
                     1'b1, 1'b0, 1'b1, make_uop(cls, alu, cmp, m1_rs1, m2_rs2, rnd[4:0],
                     rnd[9:5], rnd[14:10], 1'b1, 1'b1), '0);
            compare_class(reg_names[k], cls, out_pkt.uop.op_class);
        end
        report_test("reg_ops", err0);
    endtask

    task automatic imm_ops();
        int          err0;
        logic [31:0] rnd;
        err0 = n_errors;
        rnd = $random(seed);
        run_inst("addi", i_type(rnd[31:20], rnd[4:0], 3'd0, rnd[9:5], op_imm), 1'b1, 1'b0, 1'b1,
                 make_uop(cls_alu, alu_op_add, branch_f3_beq, m1_rs1, m2_imm, rnd[4:0], 5'd0,
                 rnd[9:5], 1'b1, 1'b0), {{20{rnd[31]}}, rnd[31:20]});
        rnd = $random(seed);
        run_inst("slti", i_type(rnd[31:20], rnd[4:0], 3'd2, rnd[9:5], op_imm), 1'b1, 1'b0, 1'b1,
                 make_uop(cls_cmp, alu_op_add, branch_f3_blt, m1_rs1, m2_imm, rnd[4:0], 5'd0,
                 rnd[9:5], 1'b1, 1'b0), {{20{rnd[31]}}, rnd[31:20]});
        rnd = $random(seed);
        run_inst("sltiu", i_type(rnd[31:20], rnd[4:0], 3'd3, rnd[9:5], op_imm), 1'b1, 1'b0,
                 1'b1, make_uop(cls_cmp, alu_op_add, branch_f3_bltu, m1_rs1, m2_imm, rnd[4:0],
                 5'd0, rnd[9:5], 1'b1, 1'b0), {{20{rnd[31]}}, rnd[31:20]});
        rnd = $random(seed);
        run_inst("srai", i_type({7'h20, rnd[24:20]}, rnd[4:0], 3'd5, rnd[9:5], op_imm), 1'b1,
                 1'b0, 1'b1, make_uop(cls_alu, alu_op_sra, branch_f3_beq, m1_rs1, m2_imm,
                 rnd[4:0], 5'd0, rnd[9:5], 1'b1, 1'b0), {20'd0, 7'h20, rnd[24:20]});
        rnd = $random(seed);
        run_inst("srli", i_type({7'h00, rnd[24:20]}, rnd[4:0], 3'd5, rnd[9:5], op_imm), 1'b1,
                 1'b0, 1'b1, make_uop(cls_alu, alu_op_srl, branch_f3_beq, m1_rs1, m2_imm,
                 rnd[4:0], 5'd0, rnd[9:5], 1'b1, 1'b0), {27'd0, rnd[24:20]});
        rnd = $random(seed);
        // random rs1 bits in the word still decode as x0
        run_inst("lui", {rnd[31:12], rnd[4:0], op_lui}, 1'b1, 1'b0, 1'b1,
                 make_uop(cls_alu, alu_op_add, branch_f3_beq, m1_rs1, m2_imm, 5'd0, 5'd0,
                 rnd[4:0], 1'b1, 1'b0), {rnd[31:12], 12'h000});
        rnd = $random(seed);
        run_inst("auipc", {rnd[31:12], rnd[4:0], op_auipc}, 1'b1, 1'b0, 1'b1,
                 make_uop(cls_alu, alu_op_add, branch_f3_beq, m1_pc, m2_imm, 5'd0, 5'd0,
                 rnd[4:0], 1'b0, 1'b0), {rnd[31:12], 12'h000});
        report_test("imm_ops", err0);
    endtask

    task automatic control_flow();
        int          err0;
        logic [31:0] rnd;
        logic [12:0] boff;
        logic [20:0] joff;
        err0 = n_errors;
        for (int k = 0; k < 6; k++) begin
            rnd  = $random(seed);
            boff = {rnd[31:20], 1'b0};
            run_inst("branch", b_type(boff, rnd[9:5], rnd[4:0], br_codes[k]), 1'b1, 1'b0, 1'b1,
                     make_uop(cls_br, alu_op_add, branch_f3_t'(br_codes[k]), m1_rs1, m2_rs2,
                     rnd[4:0], rnd[9:5], 5'd0, 1'b1, 1'b1), {{19{boff[12]}}, boff});
        end
        rnd  = $random(seed);
        joff = {rnd[31:12], 1'b0};
        run_inst("jal", j_type(joff, rnd[4:0]), 1'b1, 1'b0, 1'b1,
                 make_uop(cls_jal, alu_op_add, branch_f3_beq, m1_pc, m2_imm, 5'd0, 5'd0,
                 rnd[4:0], 1'b0, 1'b0), {{11{joff[20]}}, joff});
        rnd = $random(seed);
        run_inst("jalr", i_type(rnd[31:20], rnd[4:0], 3'd0, rnd[9:5], op_jalr), 1'b1, 1'b0, 1'b1,
                 make_uop(cls_jal, alu_op_add, branch_f3_beq, m1_rs1, m2_imm, rnd[4:0], 5'd0,
                 rnd[9:5], 1'b1, 1'b0), {{20{rnd[31]}}, rnd[31:20]});
        report_test("control_flow", err0);
    endtask

    task automatic memory_ops();
        int          err0;
        logic [31:0] rnd;
        uop_ctrl_t   u;
        err0 = n_errors;
        for (int k = 0; k < 2; k++) begin     // lb then lw
            rnd = $random(seed);
            u   = make_uop(cls_load, alu_op_add, branch_f3_beq, m1_rs1, m2_rs2, rnd[4:0], 5'd0,
                           rnd[9:5], 1'b1, 1'b0);
            u.mem_funct3 = (k == 0) ? 3'd0 : 3'd2;
            run_inst((k == 0) ? "lb" : "lw", i_type(rnd[31:20], rnd[4:0], u.mem_funct3, rnd[9:5],
                     op_load), 1'b1, 1'b0, 1'b1, u, {{20{rnd[31]}}, rnd[31:20]});
        end
        rnd = $random(seed);
        u   = make_uop(cls_store, alu_op_add, branch_f3_beq, m1_rs1, m2_rs2, rnd[4:0], rnd[9:5],
                       5'd0, 1'b1, 1'b1);
        u.mem_funct3 = 3'd2;
        run_inst("sw", s_type(rnd[31:20], rnd[9:5], rnd[4:0], 3'd2), 1'b1, 1'b0, 1'b1, u,
                 {{20{rnd[31]}}, rnd[31:20]});
        report_test("memory_ops", err0);
    endtask

    task automatic muldiv_ops();
        int          err0;
        logic [31:0] rnd;
        uop_ctrl_t   u;
        err0 = n_errors;
        for (int k = 0; k < 8; k++) begin
            rnd = $random(seed);
            u   = make_uop((k < 4) ? cls_mul : cls_div, alu_op_add, branch_f3_beq, m1_rs1, m2_rs2,
                           rnd[4:0], rnd[9:5], rnd[14:10], 1'b1, 1'b1);
            if (k < 4) begin
                u.mul_signed = (k == 3) ? 2'b00 : (k == 2) ? 2'b10 : 2'b11;
                u.mul_high   = (k != 0);
            end else begin
                u.div_signed = (k == 4 || k == 6);  // div, rem
                u.use_rem    = (k >= 6);
            end
            run_inst(md_names[k], r_type(7'b0000001, rnd[9:5], rnd[4:0], k[2:0], rnd[14:10]),
                     1'b1, 1'b0, 1'b1, u, '0);
            compare_class(md_names[k], u.op_class, out_pkt.uop.op_class);
        end
        report_test("muldiv_ops", err0);
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        pc_cur      = 32'h0000_1000;
        // live instruction held through reset
        fetch_pkt   = '{inst: i_type(12'h456, 5'd3, 3'd0, 5'd4, op_imm), pc: pc_cur,
                        valid: 1'b1};
        queue_empty = 1'b0;
        n_tests     = 0;
        n_checks    = 0;
        n_errors    = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        reset_and_gating();
        reg_ops();
        imm_ops();
        control_flow();
        memory_ops();
        muldiv_ops();
        n_errors = n_errors + dut0.u_decode_chk.n_fail;
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : decode_tb

/* bench/decode_chk.sv */
`timescale 1ns/1ps

module decode_chk
    import decode_pkg::*;
(
    input logic        clk,
    input logic        i_rst_n,
    input decode_pkt_t i_decode_pkt
);

    int n_fail = 0;

    a_bubble_zero: assert property (@(posedge clk) disable iff (!i_rst_n)
        !i_decode_pkt.valid |-> i_decode_pkt == '0)
    else begin
        $error("decode packet has nonzero fields while valid is low");
        n_fail++;
    end

    // no writeback for stores and branches
    a_no_rd: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_decode_pkt.valid && (i_decode_pkt.uop.op_class == cls_store ||
                               i_decode_pkt.uop.op_class == cls_br)
        |-> i_decode_pkt.uop.rd_addr == '0)
    else begin
        $error("store or branch carries a nonzero rd");
        n_fail++;
    end

    a_reset_zero: assert property (@(posedge clk) !i_rst_n |-> i_decode_pkt == '0)
    else begin
        $error("decode packet not cleared during reset");
        n_fail++;
    end

endmodule : decode_chk

bind decode_stage decode_chk u_decode_chk (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_decode_pkt (o_decode_pkt)
);

/* source/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
    import rv32_isa_pkg::*;
    import decode_pkg::*;
(
    input  logic        clk,
    input  logic        i_rst_n,

    input  fetch_pkt_t  i_fetch_pkt,
    input  logic        i_queue_empty,

    output decode_pkt_t o_decode_pkt
);

    ctrl_pkt_t       ctrl;
    logic [XLEN-1:0] imm;
    logic            stage_valid;
    decode_pkt_t     pkt_d;

    op_decode u_op_decode (
        .i_inst (i_fetch_pkt.inst),
        .o_ctrl (ctrl)
    );

    imm_gen u_imm_gen (
        .i_inst (i_fetch_pkt.inst),
        .i_fmt  (ctrl.imm_fmt),
        .o_imm  (imm)
    );

    // queue head only counts when the queue has something in it
    assign stage_valid = i_fetch_pkt.valid && !i_queue_empty && ctrl.legal;

    always_comb begin
        pkt_d = '0;     // bubbles leave as all zero
        if (stage_valid) begin
            pkt_d.valid = 1'b1;
            pkt_d.pc    = i_fetch_pkt.pc;
            pkt_d.uop   = ctrl.uop;
            pkt_d.imm   = imm;
        end
    end

    // loads every cycle
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_decode_pkt <= '0;
        end else begin
            o_decode_pkt <= pkt_d;
        end
    end

endmodule : decode_stage

/* decode/op_decode.sv */
`timescale 1ns/1ps

module op_decode
    import rv32_isa_pkg::*;
    import decode_pkg::*;
(
    input  logic [ILEN-1:0] i_inst,
    output ctrl_pkt_t       o_ctrl
);

    opcode_t               opcode;
    arith_f3_t             funct3;
    logic [FUNCT7_W-1:0]   funct7;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic                  alt;
    logic                  is_mdu;

    op_class_t             arith_cls;
    alu_op_t               arith_alu;
    branch_f3_t            arith_cmp;

    assign opcode = opcode_t'(i_inst[OPCODE_W-1:0]);
    assign funct3 = arith_f3_t'(i_inst[FUNCT3_LSB +: FUNCT3_W]);
    assign funct7 = i_inst[FUNCT7_LSB +: FUNCT7_W];
    assign rs1    = i_inst[RS1_LSB +: REG_ADDR_W];
    assign rs2    = i_inst[RS2_LSB +: REG_ADDR_W];
    assign rd     = i_inst[RD_LSB +: REG_ADDR_W];
    assign alt    = funct7[FUNCT7_ALT_BIT];

    // sra wins over divu when both funct7 bits are set
    assign is_mdu = (opcode == op_reg) && funct7[FUNCT7_MULDIV_BIT]
                    && !(funct3 == arith_f3_sr && alt);

    // shared by the imm and reg forms
    always_comb begin
        arith_cls = cls_alu;
        arith_alu = alu_op_t'(funct3);
        arith_cmp = branch_f3_beq;
        unique case (funct3)
            arith_f3_slt: begin
                arith_cls = cls_cmp;
                arith_alu = alu_op_add;
                arith_cmp = branch_f3_blt;
            end
            arith_f3_sltu: begin
                arith_cls = cls_cmp;
                arith_alu = alu_op_add;
                arith_cmp = branch_f3_bltu;
            end
            arith_f3_sr: arith_alu = alt ? alu_op_sra : alu_op_srl;
            arith_f3_add: begin
                if (alt && opcode == op_reg)    // no subi
                    arith_alu = alu_op_sub;
            end
            default: ;
        endcase
    end

    always_comb begin
        o_ctrl       = '0;
        o_ctrl.legal = 1'b1;
        unique case (opcode)
            op_lui: begin
                o_ctrl.uop.op_class = cls_alu;
                o_ctrl.uop.alu_op   = alu_op_add;   // x0 + u_imm
                o_ctrl.uop.m1_sel   = m1_rs1;
                o_ctrl.uop.m2_sel   = m2_imm;
                o_ctrl.uop.use_rs1  = 1'b1;
                o_ctrl.uop.rs1_addr = '0;
                o_ctrl.uop.rd_addr  = rd;
                o_ctrl.imm_fmt      = imm_u;
            end
            op_auipc: begin
                o_ctrl.uop.op_class = cls_alu;
                o_ctrl.uop.alu_op   = alu_op_add;
                o_ctrl.uop.m1_sel   = m1_pc;
                o_ctrl.uop.m2_sel   = m2_imm;
                o_ctrl.uop.rd_addr  = rd;
                o_ctrl.imm_fmt      = imm_u;
            end
            op_imm: begin
                o_ctrl.uop.op_class = arith_cls;
                o_ctrl.uop.alu_op   = arith_alu;
                o_ctrl.uop.cmp_op   = arith_cmp;
                o_ctrl.uop.m1_sel   = m1_rs1;
                o_ctrl.uop.m2_sel   = m2_imm;
                o_ctrl.uop.use_rs1  = 1'b1;
                o_ctrl.uop.rs1_addr = rs1;
                o_ctrl.uop.rd_addr  = rd;
                o_ctrl.imm_fmt      = imm_i;
            end
            op_reg: begin
                o_ctrl.uop.m1_sel   = m1_rs1;
                o_ctrl.uop.m2_sel   = m2_rs2;
                o_ctrl.uop.use_rs1  = 1'b1;
                o_ctrl.uop.use_rs2  = 1'b1;
                o_ctrl.uop.rs1_addr = rs1;
                o_ctrl.uop.rs2_addr = rs2;
                o_ctrl.uop.rd_addr  = rd;
                if (is_mdu) begin
                    o_ctrl.uop.op_class = funct3[2] ? cls_div : cls_mul;
                    unique case (funct3)
                        arith_f3_add: o_ctrl.uop.mul_signed = 2'b11;   // mul
                        arith_f3_sll: begin                            // mulh
                            o_ctrl.uop.mul_signed = 2'b11;
                            o_ctrl.uop.mul_high   = 1'b1;
                        end
                        arith_f3_slt: begin                            // mulhsu
                            o_ctrl.uop.mul_signed = 2'b10;
                            o_ctrl.uop.mul_high   = 1'b1;
                        end
                        arith_f3_sltu: o_ctrl.uop.mul_high = 1'b1;     // mulhu
                        arith_f3_xor:  o_ctrl.uop.div_signed = 1'b1;   // div
                        arith_f3_sr:   o_ctrl.uop.div_signed = 1'b0;   // divu
                        arith_f3_or: begin                             // rem
                            o_ctrl.uop.div_signed = 1'b1;
                            o_ctrl.uop.use_rem    = 1'b1;
                        end
                        default: o_ctrl.uop.use_rem = 1'b1;            // remu
                    endcase
                end else begin
                    o_ctrl.uop.op_class = arith_cls;
                    o_ctrl.uop.alu_op   = arith_alu;
                    o_ctrl.uop.cmp_op   = arith_cmp;
                end
            end
            op_br: begin
                o_ctrl.uop.op_class = cls_br;
                o_ctrl.uop.cmp_op   = branch_f3_t'(funct3);
                o_ctrl.uop.m1_sel   = m1_rs1;
                o_ctrl.uop.m2_sel   = m2_rs2;
                o_ctrl.uop.use_rs1  = 1'b1;
                o_ctrl.uop.use_rs2  = 1'b1;
                o_ctrl.uop.rs1_addr = rs1;
                o_ctrl.uop.rs2_addr = rs2;
                o_ctrl.uop.rd_addr  = '0;           // no writeback
                o_ctrl.imm_fmt      = imm_b;
            end
            op_jal: begin
                o_ctrl.uop.op_class = cls_jal;
                o_ctrl.uop.alu_op   = alu_op_add;   // target = pc + j_imm
                o_ctrl.uop.m1_sel   = m1_pc;
                o_ctrl.uop.m2_sel   = m2_imm;
                o_ctrl.uop.rd_addr  = rd;
                o_ctrl.imm_fmt      = imm_j;
            end
            op_jalr: begin
                o_ctrl.uop.op_class = cls_jal;
                o_ctrl.uop.alu_op   = alu_op_add;
                o_ctrl.uop.m1_sel   = m1_rs1;
                o_ctrl.uop.m2_sel   = m2_imm;
                o_ctrl.uop.use_rs1  = 1'b1;
                o_ctrl.uop.rs1_addr = rs1;
                o_ctrl.uop.rd_addr  = rd;
                o_ctrl.imm_fmt      = imm_i;
            end
            op_load: begin
                o_ctrl.uop.op_class   = cls_load;
                o_ctrl.uop.use_rs1    = 1'b1;
                o_ctrl.uop.rs1_addr   = rs1;
                o_ctrl.uop.rd_addr    = rd;
                o_ctrl.uop.mem_funct3 = funct3;
                o_ctrl.imm_fmt        = imm_i;
            end
            op_store: begin
                o_ctrl.uop.op_class   = cls_store;
                o_ctrl.uop.use_rs1    = 1'b1;
                o_ctrl.uop.use_rs2    = 1'b1;
                o_ctrl.uop.rs1_addr   = rs1;
                o_ctrl.uop.rs2_addr   = rs2;
                o_ctrl.uop.rd_addr    = '0;
                o_ctrl.uop.mem_funct3 = funct3;
                o_ctrl.imm_fmt        = imm_s;
            end
            default: o_ctrl.legal = 1'b0;   // unknown opcode is dropped
        endcase
    end

endmodule : op_decode

/* decode/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen
    import rv32_isa_pkg::*;
    import decode_pkg::*;
(
    input  logic [ILEN-1:0] i_inst,
    input  imm_fmt_t        i_fmt,
    output logic [XLEN-1:0] o_imm
);

    logic [XLEN-1:0] imm_i_val;
    logic [XLEN-1:0] imm_s_val;
    logic [XLEN-1:0] imm_b_val;
    logic [XLEN-1:0] imm_u_val;
    logic [XLEN-1:0] imm_j_val;

    // all formats sign extend from inst[31]
    assign imm_i_val = {{(XLEN-11){i_inst[31]}}, i_inst[30:20]};
    assign imm_s_val = {{(XLEN-11){i_inst[31]}}, i_inst[30:25], i_inst[11:7]};
    assign imm_b_val = {{(XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25],
                        i_inst[11:8], 1'b0};
    assign imm_u_val = {i_inst[31:12], 12'h000};
    assign imm_j_val = {{(XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20],
                        i_inst[30:21], 1'b0};

    always_comb begin
        unique case (i_fmt)
            imm_i:   o_imm = imm_i_val;
            imm_s:   o_imm = imm_s_val;
            imm_b:   o_imm = imm_b_val;
            imm_u:   o_imm = imm_u_val;
            imm_j:   o_imm = imm_j_val;
            default: o_imm = '0;    // imm_none
        endcase
    end

endmodule : imm_gen

/* common/decode_pkg.sv */
package decode_pkg;
    import rv32_isa_pkg::*;

    // head of the instruction queue
    typedef struct packed {
        logic [ILEN-1:0] inst;
        logic [XLEN-1:0] pc;
        logic            valid;
    } fetch_pkt_t;

    typedef enum logic [2:0] {
        cls_alu,
        cls_cmp,
        cls_mul,
        cls_div,
        cls_br,
        cls_jal,
        cls_load,
        cls_store
    } op_class_t;

    // plain funct3 codes land on the same value
    typedef enum logic [FUNCT3_W-1:0] {
        alu_op_add = 3'd0,
        alu_op_sll = 3'd1,
        alu_op_sra = 3'd2,
        alu_op_sub = 3'd3,
        alu_op_xor = 3'd4,
        alu_op_srl = 3'd5,
        alu_op_or  = 3'd6,
        alu_op_and = 3'd7
    } alu_op_t;

    typedef enum logic {
        m1_rs1 = 1'b0,
        m1_pc  = 1'b1
    } m1_sel_t;

    typedef enum logic {
        m2_rs2 = 1'b0,
        m2_imm = 1'b1
    } m2_sel_t;

    typedef enum logic [2:0] {
        imm_none,
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_fmt_t;

    // fields that travel down the pipe
    typedef struct packed {
        op_class_t             op_class;
        alu_op_t               alu_op;
        branch_f3_t            cmp_op;
        m1_sel_t               m1_sel;
        m2_sel_t               m2_sel;
        logic [REG_ADDR_W-1:0] rs1_addr;
        logic [REG_ADDR_W-1:0] rs2_addr;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic                  use_rs1;
        logic                  use_rs2;
        logic [FUNCT3_W-1:0]   mem_funct3;
        logic [1:0]            mul_signed;  // {rs1 signed, rs2 signed}
        logic                  mul_high;
        logic                  div_signed;
        logic                  use_rem;
    } uop_ctrl_t;

    typedef struct packed {
        uop_ctrl_t uop;
        imm_fmt_t  imm_fmt;
        logic      legal;
    } ctrl_pkt_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        uop_ctrl_t       uop;
        logic [XLEN-1:0] imm;
    } decode_pkt_t;

endpackage : decode_pkg

/* common/rv32_isa_pkg.sv */
package rv32_isa_pkg;

    localparam int ILEN       = 32;
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;

    // field positions in the instruction word
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    localparam int FUNCT7_ALT_BIT    = 5;   // sub / sra
    localparam int FUNCT7_MULDIV_BIT = 0;   // m extension on the reg opcode

    typedef enum logic [OPCODE_W-1:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_br    = 7'b1100011,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } opcode_t;

    typedef enum logic [FUNCT3_W-1:0] {
        arith_f3_add  = 3'b000,     // also sub
        arith_f3_sll  = 3'b001,
        arith_f3_slt  = 3'b010,
        arith_f3_sltu = 3'b011,
        arith_f3_xor  = 3'b100,
        arith_f3_sr   = 3'b101,     // srl or sra
        arith_f3_or   = 3'b110,
        arith_f3_and  = 3'b111
    } arith_f3_t;

    // compare codes as they appear in branch funct3
    typedef enum logic [FUNCT3_W-1:0] {
        branch_f3_beq  = 3'b000,
        branch_f3_bne  = 3'b001,
        branch_f3_blt  = 3'b100,
        branch_f3_bge  = 3'b101,
        branch_f3_bltu = 3'b110,
        branch_f3_bgeu = 3'b111
    } branch_f3_t;

endpackage : rv32_isa_pkg
